// File: flist.f
logic/axi_sram_pkg.sv
logic/axi_sram_ctrl.sv
logic/axi_sram_rd_path.sv
logic/axi_sram_wr_path.sv
logic/sram_array.sv
logic/axi_sram.sv
sim/axi_sram_assert.sv
sim/tb_axi_sram.sv

// File: sim/tb_axi_sram.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_sram;

  localparam int mem_words   = 256;
  localparam int read_cycles = 2;
  localparam int pool_words  = 16;
  localparam int n_random    = 300;
  // a concurrent step counts as two
  localparam int n_txn       = 2 * pool_words + 2 * n_random;
  localparam int period      = 20;

  logic                aclk;
  logic                areset;
  axi_sram_pkg::addr_t araddr;
  logic                arvalid;
  logic                arready;
  axi_sram_pkg::data_t rdata;
  axi_sram_pkg::resp_t rresp;
  logic                rvalid;
  logic                rready;
  axi_sram_pkg::addr_t awaddr;
  logic                awvalid;
  logic                awready;
  axi_sram_pkg::data_t wdata;
  axi_sram_pkg::strb_t wstrb;
  logic                wvalid;
  logic                wready;
  axi_sram_pkg::resp_t bresp;
  logic                bvalid;
  logic                bready;

  // byte-wise image of what the memory should hold
  logic [7:0]          ref_mem [4*mem_words];
  axi_sram_pkg::addr_t pool [pool_words];
  int                  r_count = 0;
  int                  b_count = 0;
  int                  r_expected = 0;
  int                  b_expected = 0;
  logic                rvalid_seen = 1'b0;
  logic                bvalid_seen = 1'b0;

  axi_sram #(
    .mem_words   (mem_words),
    .read_cycles (read_cycles)
  ) i_axi_sram (.*);

  always #(period/2) aclk = ~aclk;

  // every response is its own valid pulse, counted where it rises
  always @(posedge aclk) begin
    if (rvalid === 1'b1 && !rvalid_seen) r_count++;
    if (bvalid === 1'b1 && !bvalid_seen) b_count++;
    rvalid_seen = (rvalid === 1'b1);
    bvalid_seen = (bvalid === 1'b1);
  end

  always @(i_axi_sram.i_axi_sram_assert.fail_count) begin
    if (i_axi_sram.i_axi_sram_assert.fail_count != 0) begin
      $display("protocol assertion failed at %0t", $time);
      $display("tests failed");
      $fatal(1, "bound protocol assertion failed");
    end
  end

  function automatic bit in_range(input axi_sram_pkg::addr_t addr);
    return addr[31:2] < mem_words;
  endfunction

  function automatic axi_sram_pkg::data_t expected_word(input axi_sram_pkg::addr_t addr);
    axi_sram_pkg::data_t word;
    word = '0;
    if (in_range(addr)) begin
      for (int b = 0; b < 4; b++) begin
        word[8*b +: 8] = ref_mem[4*int'(addr[31:2]) + b];
      end
    end
    return word;
  endfunction

  function automatic axi_sram_pkg::addr_t bad_addr();
    if ($urandom_range(3) == 0) return 32'hffff_fffc;
    return axi_sram_pkg::addr_t'(4 * (mem_words + $urandom_range(15)));
  endfunction

  task automatic send_aw(input axi_sram_pkg::addr_t addr);
    @(negedge aclk);
    awaddr  = addr;
    awvalid = 1'b1;
    while (!awready) @(negedge aclk);
    @(negedge aclk);
    awvalid = 1'b0;
  endtask

  task automatic send_w(input axi_sram_pkg::data_t data, input axi_sram_pkg::strb_t strb);
    @(negedge aclk);
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    while (!wready) @(negedge aclk);
    @(negedge aclk);
    wvalid = 1'b0;
  endtask

  // order 0 puts AW first, 1 puts W first, 2 sends both together
  task automatic write_word(input axi_sram_pkg::addr_t addr, input axi_sram_pkg::data_t data,
                            input axi_sram_pkg::strb_t strb, input int order);
    axi_sram_pkg::resp_t exp_resp;
    bit                  done;
    exp_resp = in_range(addr) ? axi_sram_pkg::resp_okay : axi_sram_pkg::resp_slverr;
    case (order)
      0: begin
        send_aw(addr);
        send_w(data, strb);
      end
      1: begin
        send_w(data, strb);
        send_aw(addr);
      end
      default: begin
        fork
          send_aw(addr);
          send_w(data, strb);
        join
      end
    endcase
    done = 1'b0;
    while (!done) begin
      @(negedge aclk);
      bready = ($urandom_range(3) != 0);
      if (bvalid && bready) begin
        assert (bresp === exp_resp) else begin
          $display("mismatch at %0t: write to %h gave bresp %0d, expected %0d",
                   $time, addr, bresp, exp_resp);
          $display("tests failed");
          $fatal(1, "write response check");
        end
        done = 1'b1;
      end
    end
    @(negedge aclk);
    bready = 1'b0;
    if (in_range(addr)) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) ref_mem[4*int'(addr[31:2]) + b] = data[8*b +: 8];
      end
    end
    b_expected++;
  endtask

  task automatic read_word(input axi_sram_pkg::addr_t addr);
    axi_sram_pkg::data_t exp_data;
    axi_sram_pkg::resp_t exp_resp;
    bit                  done;
    exp_data = expected_word(addr);
    exp_resp = in_range(addr) ? axi_sram_pkg::resp_okay : axi_sram_pkg::resp_slverr;
    @(negedge aclk);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge aclk);
    @(negedge aclk);
    arvalid = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge aclk);
      rready = ($urandom_range(3) != 0);
      if (rvalid && rready) begin
        assert (rdata === exp_data && rresp === exp_resp) else begin
          $display("mismatch at %0t: read of %h gave %h/%0d, expected %h/%0d",
                   $time, addr, rdata, rresp, exp_data, exp_resp);
          $display("tests failed");
          $fatal(1, "read data check");
        end
        done = 1'b1;
      end
    end
    @(negedge aclk);
    rready = 1'b0;
    r_expected++;
  endtask

  initial begin
    #((n_txn * 40 + 10) * period);
    $display("timeout, the transactions did not finish in the expected time");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int ia;
    int ib;
    int kind;
    void'($urandom(32'h1fb0));
    aclk    = 1'b0;
    areset  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    repeat (4) @(negedge aclk);
    areset = 1'b0;

    // spread over the array, first and last word included
    for (int i = 0; i < pool_words; i++) begin
      pool[i] = axi_sram_pkg::addr_t'(4 * ((i * 17) % mem_words));
      write_word(pool[i], axi_sram_pkg::data_t'($urandom), 4'hf, i % 3);
      read_word(pool[i]);
    end

    for (int n = 0; n < n_random; n++) begin
      ia   = $urandom_range(pool_words - 1);
      ib   = (ia + 1 + $urandom_range(pool_words - 2)) % pool_words;
      kind = $urandom_range(6);
      repeat ($urandom_range(2)) @(negedge aclk);
      case (kind)
        0: write_word(bad_addr(), axi_sram_pkg::data_t'($urandom),
                      axi_sram_pkg::strb_t'($urandom_range(1, 15)), $urandom_range(2));
        1: read_word(bad_addr());
        2, 3: begin
          fork
            write_word(pool[ia], axi_sram_pkg::data_t'($urandom),
                       axi_sram_pkg::strb_t'($urandom_range(1, 15)), $urandom_range(2));
            read_word(pool[ib]);
          join
        end
        4: write_word(pool[ia], axi_sram_pkg::data_t'($urandom),
                      axi_sram_pkg::strb_t'($urandom_range(1, 15)), $urandom_range(2));
        default: read_word(pool[ia]);
      endcase
    end

    repeat (4) @(negedge aclk);
    if (r_count == r_expected && b_count == b_expected && !rvalid && !bvalid &&
        i_axi_sram.i_axi_sram_assert.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("mismatch at %0t: %0d rvalid pulses for %0d reads, %0d bvalid pulses for %0d writes",
               $time, r_count, r_expected, b_count, b_expected);
      $display("tests failed");
      $fatal(1, "response count check");
    end
  end

endmodule

`default_nettype wire

// File: sim/axi_sram_assert.sv
`timescale 1ns/10ps
`default_nettype none

module axi_sram_assert (
  input logic                 aclk,
  input logic                 areset,
  input logic                 arready,
  input logic                 awready,
  input logic                 wready,
  input logic                 rvalid,
  input logic                 rready,
  input logic                 bvalid,
  input logic                 bready,
  input logic                 mem_en,
  input axi_sram_pkg::data_t  rdata,
  input axi_sram_pkg::resp_t  rresp,
  input axi_sram_pkg::resp_t  bresp
);

  int fail_count = 0;

  // read response parked while the master stalls
  r_hold: assert property (@(posedge aclk) disable iff (areset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
  else begin
    $error("rvalid dropped or rdata/rresp moved before rready");
    fail_count++;
  end

  b_hold: assert property (@(posedge aclk) disable iff (areset)
    bvalid && !bready |=> bvalid && $stable(bresp))
  else begin
    $error("bvalid dropped or bresp moved before bready");
    fail_count++;
  end

  // one outstanding per channel, so a taken response never repeats right away
  r_single: assert property (@(posedge aclk) disable iff (areset)
    rvalid && rready |=> !rvalid)
  else begin
    $error("rvalid still high after the R handshake");
    fail_count++;
  end

  b_single: assert property (@(posedge aclk) disable iff (areset)
    bvalid && bready |=> !bvalid)
  else begin
    $error("bvalid still high after the B handshake");
    fail_count++;
  end

  in_reset: assert property (@(posedge aclk)
    areset |=> !arready && !awready && !wready && !rvalid && !bvalid && !mem_en)
  else begin
    $error("handshake outputs or mem_en high during reset");
    fail_count++;
  end

  out_of_reset: assert property (@(posedge aclk)
    $fell(areset) |=> arready && awready && wready)
  else begin
    $error("channel readies not high one cycle after reset release");
    fail_count++;
  end

endmodule

bind axi_sram axi_sram_assert i_axi_sram_assert (.*);

`default_nettype wire

// File: logic/axi_sram.sv
`timescale 1ns/10ps
`default_nettype none

module axi_sram #(
  parameter int mem_words = 256,
  parameter int read_cycles = 1
) (
  input  logic                 aclk,
  input  logic                 areset,
  input  axi_sram_pkg::addr_t  araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output axi_sram_pkg::data_t  rdata,
  output axi_sram_pkg::resp_t  rresp,
  output logic                 rvalid,
  input  logic                 rready,
  input  axi_sram_pkg::addr_t  awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  axi_sram_pkg::data_t  wdata,
  input  axi_sram_pkg::strb_t  wstrb,
  input  logic                 wvalid,
  output logic                 wready,
  output axi_sram_pkg::resp_t  bresp,
  output logic                 bvalid,
  input  logic                 bready
);

  localparam int index_w = (mem_words > 1) ? $clog2(mem_words) : 1;

  logic                ar_take;
  logic                aw_take;
  logic                w_take;
  logic                r_load;
  logic                b_load;
  axi_sram_pkg::resp_t r_resp;
  axi_sram_pkg::resp_t b_resp;
  axi_sram_pkg::addr_t rd_addr;
  axi_sram_pkg::addr_t wr_addr;
  axi_sram_pkg::data_t wr_data;
  axi_sram_pkg::strb_t wr_strb;

  // single memory port
  logic                mem_en;
  logic                mem_we;
  logic [index_w-1:0]  mem_index;
  axi_sram_pkg::data_t mem_wdata;
  axi_sram_pkg::strb_t mem_be;
  axi_sram_pkg::data_t mem_rdata;
  logic                mem_rvalid;

  axi_sram_ctrl #(
    .mem_words   (mem_words),
    .read_cycles (read_cycles)
  ) i_ctrl (
    .aclk, .areset, .arvalid, .rready, .awvalid, .wvalid, .bready,
    .rd_addr, .wr_addr, .wr_data, .wr_strb, .mem_rvalid,
    .arready, .awready, .wready, .ar_take, .aw_take, .w_take,
    .r_load, .r_resp, .b_load, .b_resp,
    .mem_en, .mem_we, .mem_index, .mem_wdata, .mem_be
  );

  axi_sram_rd_path i_rd_path (
    .aclk, .areset, .araddr, .ar_take, .r_load, .r_resp, .mem_rdata, .rready,
    .rd_addr, .rdata, .rresp, .rvalid
  );

  axi_sram_wr_path i_wr_path (
    .aclk, .areset, .awaddr, .aw_take, .wdata, .wstrb, .w_take,
    .b_load, .b_resp, .bready,
    .wr_addr, .wr_data, .wr_strb, .bresp, .bvalid
  );

  sram_array #(
    .mem_words   (mem_words),
    .read_cycles (read_cycles)
  ) i_sram_array (
    .aclk, .mem_en, .mem_we, .mem_index, .mem_wdata, .mem_be,
    .mem_rdata, .mem_rvalid
  );

endmodule

`default_nettype wire

// File: logic/sram_array.sv
`timescale 1ns/10ps
`default_nettype none

module sram_array #(
  parameter int mem_words = 256,
  parameter int read_cycles = 1,
  localparam int index_w = (mem_words > 1) ? $clog2(mem_words) : 1
) (
  input  logic                 aclk,
  input  logic                 mem_en,
  input  logic                 mem_we,
  input  logic [index_w-1:0]   mem_index,
  input  axi_sram_pkg::data_t  mem_wdata,
  input  axi_sram_pkg::strb_t  mem_be,
  output axi_sram_pkg::data_t  mem_rdata,
  output logic                 mem_rvalid
);

  localparam int n_bytes = $bits(axi_sram_pkg::strb_t);

  axi_sram_pkg::data_t mem [mem_words];

  // stage 0 is the array read itself
  axi_sram_pkg::data_t data_pipe  [read_cycles];
  logic                valid_pipe [read_cycles];

  always_ff @(posedge aclk) begin
    if (mem_en && mem_we) begin
      for (int b = 0; b < n_bytes; b++) begin
        if (mem_be[b]) begin
          mem[mem_index][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  // read pipeline, one stage per cycle of latency
  always_ff @(posedge aclk) begin
    data_pipe[0]  <= mem[mem_index];
    valid_pipe[0] <= mem_en && !mem_we;
    for (int s = 1; s < read_cycles; s++) begin
      data_pipe[s]  <= data_pipe[s-1];
      valid_pipe[s] <= valid_pipe[s-1];
    end
  end

  assign mem_rdata  = data_pipe[read_cycles-1];
  assign mem_rvalid = valid_pipe[read_cycles-1];

endmodule

`default_nettype wire

// File: logic/axi_sram_wr_path.sv
`timescale 1ns/10ps
`default_nettype none

module axi_sram_wr_path (
  input  logic                 aclk,
  input  logic                 areset,
  input  axi_sram_pkg::addr_t  awaddr,
  input  logic                 aw_take,
  input  axi_sram_pkg::data_t  wdata,
  input  axi_sram_pkg::strb_t  wstrb,
  input  logic                 w_take,
  input  logic                 b_load,
  input  axi_sram_pkg::resp_t  b_resp,
  input  logic                 bready,
  output axi_sram_pkg::addr_t  wr_addr,
  output axi_sram_pkg::data_t  wr_data,
  output axi_sram_pkg::strb_t  wr_strb,
  output axi_sram_pkg::resp_t  bresp,
  output logic                 bvalid
);

  // address and data land on their own strobes, in any order
  always_ff @(posedge aclk) begin
    if (aw_take) begin
      wr_addr <= awaddr;
    end
  end

  always_ff @(posedge aclk) begin
    if (w_take) begin
      wr_data <= wdata;
      wr_strb <= wstrb;
    end
  end

  always_ff @(posedge aclk) begin
    if (b_load) begin
      bresp <= b_resp;
    end
  end

  // held high until the master takes it
  always_ff @(posedge aclk) begin
    if (areset) begin
      bvalid <= 1'b0;
    end else if (b_load) begin
      bvalid <= 1'b1;
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/axi_sram_rd_path.sv
`timescale 1ns/10ps
`default_nettype none

module axi_sram_rd_path (
  input  logic                 aclk,
  input  logic                 areset,
  input  axi_sram_pkg::addr_t  araddr,
  input  logic                 ar_take,
  input  logic                 r_load,
  input  axi_sram_pkg::resp_t  r_resp,
  input  axi_sram_pkg::data_t  mem_rdata,
  input  logic                 rready,
  output axi_sram_pkg::addr_t  rd_addr,
  output axi_sram_pkg::data_t  rdata,
  output axi_sram_pkg::resp_t  rresp,
  output logic                 rvalid
);

  // address held until the next AR handshake
  always_ff @(posedge aclk) begin
    if (ar_take) begin
      rd_addr <= araddr;
    end
  end

  // error responses carry zero data
  always_ff @(posedge aclk) begin
    if (r_load) begin
      rresp <= r_resp;
      if (r_resp == axi_sram_pkg::resp_okay) begin
        rdata <= mem_rdata;
      end else begin
        rdata <= '0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      rvalid <= 1'b0;
    end else if (r_load) begin
      rvalid <= 1'b1;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/axi_sram_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module axi_sram_ctrl #(
  parameter int mem_words = 256,
  parameter int read_cycles = 1,
  localparam int index_w = (mem_words > 1) ? $clog2(mem_words) : 1,
  localparam int cnt_w = $clog2(read_cycles + 1)
) (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  arvalid,
  input  logic                  rready,
  input  logic                  awvalid,
  input  logic                  wvalid,
  input  logic                  bready,
  input  axi_sram_pkg::addr_t   rd_addr,
  input  axi_sram_pkg::addr_t   wr_addr,
  input  axi_sram_pkg::data_t   wr_data,
  input  axi_sram_pkg::strb_t   wr_strb,
  input  logic                  mem_rvalid,
  output logic                  arready,
  output logic                  awready,
  output logic                  wready,
  output logic                  ar_take,
  output logic                  aw_take,
  output logic                  w_take,
  output logic                  r_load,
  output axi_sram_pkg::resp_t   r_resp,
  output logic                  b_load,
  output axi_sram_pkg::resp_t   b_resp,
  output logic                  mem_en,
  output logic                  mem_we,
  output logic [index_w-1:0]    mem_index,
  output axi_sram_pkg::data_t   mem_wdata,
  output axi_sram_pkg::strb_t   mem_be
);

  localparam logic [29:0] word_limit = 30'(mem_words);

  axi_sram_pkg::rd_state_t rd_state;
  axi_sram_pkg::rd_state_t rd_next;
  axi_sram_pkg::wr_state_t wr_state;
  axi_sram_pkg::wr_state_t wr_next;

  logic             run;
  logic             aw_got;
  logic             w_got;
  logic             last_wr;
  logic             rd_err;
  logic             wr_err;
  logic             rd_req;
  logic             wr_req;
  logic             rd_gnt;
  logic             wr_gnt;
  logic [cnt_w-1:0] rd_cnt;

  // word index past the end of the array
  assign rd_err = rd_addr[31:2] >= word_limit;
  assign wr_err = wr_addr[31:2] >= word_limit;

  // readies only open once the first cycle out of reset has passed
  assign arready = run && (rd_state == axi_sram_pkg::rd_idle);
  assign awready = run && !aw_got &&
                   (wr_state == axi_sram_pkg::wr_idle || wr_state == axi_sram_pkg::wr_collect);
  assign wready  = run && !w_got &&
                   (wr_state == axi_sram_pkg::wr_idle || wr_state == axi_sram_pkg::wr_collect);

  assign ar_take = arvalid && arready;
  assign aw_take = awvalid && awready;
  assign w_take  = wvalid && wready;

  // alternating priority, the side not served last wins a tie
  assign rd_req = (rd_state == axi_sram_pkg::rd_wait_grant) && !rd_err;
  assign wr_req = (wr_state == axi_sram_pkg::wr_wait_grant) && !wr_err;
  assign rd_gnt = rd_req && (!wr_req || last_wr);
  assign wr_gnt = wr_req && !rd_gnt;

  // data only counts once this read's pipeline slot comes up
  assign r_load = (rd_state == axi_sram_pkg::rd_mem) &&
                  (rd_err || (mem_rvalid && rd_cnt == '0));
  assign r_resp = rd_err ? axi_sram_pkg::resp_slverr : axi_sram_pkg::resp_okay;
  assign b_resp = wr_err ? axi_sram_pkg::resp_slverr : axi_sram_pkg::resp_okay;

  always_comb begin
    rd_next = rd_state;
    case (rd_state)
      axi_sram_pkg::rd_idle:       if (ar_take) rd_next = axi_sram_pkg::rd_wait_grant;
      axi_sram_pkg::rd_wait_grant: if (rd_err || rd_gnt) rd_next = axi_sram_pkg::rd_mem;
      axi_sram_pkg::rd_mem:        if (r_load) rd_next = axi_sram_pkg::rd_resp;
      axi_sram_pkg::rd_resp:       if (rready) rd_next = axi_sram_pkg::rd_idle;
      default:                     rd_next = axi_sram_pkg::rd_idle;
    endcase
  end

  always_comb begin
    wr_next = wr_state;
    case (wr_state)
      axi_sram_pkg::wr_idle: begin
        if (aw_take && w_take) begin
          wr_next = axi_sram_pkg::wr_wait_grant;
        end else if (aw_take || w_take) begin
          wr_next = axi_sram_pkg::wr_collect;
        end
      end
      axi_sram_pkg::wr_collect: begin
        if ((aw_got || aw_take) && (w_got || w_take)) begin
          wr_next = axi_sram_pkg::wr_wait_grant;
        end
      end
      axi_sram_pkg::wr_wait_grant: begin
        if (wr_err || wr_gnt) wr_next = axi_sram_pkg::wr_resp;
      end
      axi_sram_pkg::wr_resp: begin
        // bvalid is up once neither the load nor the write itself is pending
        if (bready && !b_load && !(mem_en && mem_we)) wr_next = axi_sram_pkg::wr_idle;
      end
      default: wr_next = axi_sram_pkg::wr_idle;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      run      <= 1'b0;
      rd_state <= axi_sram_pkg::rd_idle;
      wr_state <= axi_sram_pkg::wr_idle;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      last_wr  <= 1'b0;
      mem_en   <= 1'b0;
      mem_we   <= 1'b0;
      b_load   <= 1'b0;
      rd_cnt   <= '0;
    end else begin
      run      <= 1'b1;
      rd_state <= rd_next;
      wr_state <= wr_next;
      mem_en   <= rd_gnt || wr_gnt;
      mem_we   <= wr_gnt;
      b_load   <= (mem_en && mem_we) ||
                  (wr_state == axi_sram_pkg::wr_wait_grant && wr_err);
      if (rd_gnt) begin
        last_wr <= 1'b0;
      end else if (wr_gnt) begin
        last_wr <= 1'b1;
      end
      if (wr_next == axi_sram_pkg::wr_wait_grant) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end else begin
        if (aw_take) aw_got <= 1'b1;
        if (w_take) w_got <= 1'b1;
      end
      if (rd_gnt) begin
        rd_cnt <= cnt_w'(read_cycles);
      end else if (rd_cnt != '0) begin
        rd_cnt <= rd_cnt - 1'b1;
      end
    end
  end

  // memory port payload
  always_ff @(posedge aclk) begin
    if (rd_gnt) begin
      mem_index <= rd_addr[index_w+1:2];
    end else if (wr_gnt) begin
      mem_index <= wr_addr[index_w+1:2];
      mem_wdata <= wr_data;
      mem_be    <= wr_strb;
    end
  end

endmodule

`default_nettype wire

// File: logic/axi_sram_pkg.sv
`default_nettype none

package axi_sram_pkg;

  // byte address as seen on the AXI side
  typedef logic [31:0] addr_t;

  // one memory word
  typedef logic [31:0] data_t;

  // one enable per byte of data_t
  typedef logic [3:0] strb_t;

  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay   = 2'd0;
  localparam resp_t resp_slverr = 2'd2;

  typedef enum logic [1:0] {
    rd_idle,
    rd_wait_grant,
    rd_mem,
    rd_resp
  } rd_state_t;

  typedef enum logic [1:0] {
    wr_idle,
    wr_collect,
    wr_wait_grant,
    wr_resp
  } wr_state_t;

endpackage

`default_nettype wire
